// File: src/dcache_pkg.sv
package dcache_pkg;

    // data path widths
    typedef logic [31 : 0]  word_t;         // data or address word
    typedef logic [7  : 0]  byte_t;         // one byte lane
    typedef logic [3  : 0]  byte_en_t;      // one bit per lane, lane 0 is bits 7:0

    // access size as driven by the load/store unit
    typedef logic [1  : 0]  size_t;         // encoded access size

    localparam size_t   SIZE_BYTE = 2'b00;  // 8 bit access
    localparam size_t   SIZE_HALF = 2'b01;  // 16 bit access, aligned to a half
    localparam size_t   SIZE_WORD = 2'b10;  // 32 bit access, aligned to a word

endpackage : dcache_pkg

// File: src/dcache_bank.sv
module dcache_bank
#(
    parameter   addr_w = 6                          // line index width
)(
    input   logic                   clk,            // clock
    input   logic                   rst_n_i,        // async reset, active low
    input   logic   [addr_w-1 : 0]  line_i,         // line index
    input   logic                   we_i,           // lane write enable
    input   logic                   vld_i,          // new valid bit
    input   dcache_pkg::byte_t      wd_i,           // byte to write
    output  logic                   vld_o,          // valid of addressed line
    output  dcache_pkg::byte_t      rd_o            // byte of addressed line
);

    import dcache_pkg::*;

    localparam  depth = 2 ** addr_w;                // lines in the cache

    byte_t                  mem   [depth];          // data bytes
    logic   [depth-1 : 0]   vld_q;                  // valid per line

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[line_i] <= wd_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;                            // empty cache after reset
        end else if (we_i) begin
            vld_q[line_i] <= vld_i;
        end
    end

    assign vld_o = vld_q[line_i];
    assign rd_o  = mem[line_i];

endmodule : dcache_bank

// File: src/dcache_tag_store.sv
module dcache_tag_store
#(
    parameter   addr_w = 6,                         // line index width
                tag_w  = 6                          // tag field width
)(
    input   logic                   clk,            // clock
    input   logic   [addr_w-1 : 0]  line_i,         // line index
    input   logic                   we_i,           // tag write enable
    input   logic   [tag_w-1  : 0]  wtag_i,         // tag to store
    input   logic   [tag_w-1  : 0]  ltag_i,         // tag of the lookup address
    output  logic                   tag_match_o     // stored tag equals lookup tag
);

    localparam  depth = 2 ** addr_w;                // lines in the cache

    logic   [tag_w-1 : 0]   tags [depth];           // one tag per line

    always_ff @(posedge clk) begin
        if (we_i) begin
            tags[line_i] <= wtag_i;
        end
    end

    // only compare in the design
    assign tag_match_o = (tags[line_i] == ltag_i);

endmodule : dcache_tag_store

// File: src/dcache_read_merge.sv
module dcache_read_merge
(
    input   dcache_pkg::byte_en_t   lane_vld_i,     // valid from each bank
    input   logic                   tag_match_i,    // from tag store
    input   dcache_pkg::byte_en_t   rd_en_i,        // lanes the load needs
    input   dcache_pkg::word_t      lane_rd_i,      // bytes from all banks
    input   logic   [1 : 0]         addr_lo_i,      // byte offset in the word
    input   dcache_pkg::size_t      size_i,         // load size
    output  logic                   load_hit_o,     // all needed bytes present
    output  dcache_pkg::word_t      load_dat_o      // aligned load data
);

    import dcache_pkg::*;

    byte_en_t   miss_lanes;                         // needed but not valid
    word_t      shifted;                            // addressed byte moved to bit 0

    assign miss_lanes = rd_en_i & ~lane_vld_i;
    assign load_hit_o = tag_match_i && (miss_lanes == '0);

    assign shifted = lane_rd_i >> {addr_lo_i, 3'b000};     // offset times eight

    // zero extend by size
    always_comb begin
        case (size_i)
            SIZE_BYTE   : load_dat_o = {24'h0, shifted[7  : 0]};
            SIZE_HALF   : load_dat_o = {16'h0, shifted[15 : 0]};
            default     : load_dat_o = lane_rd_i;          // whole word, no shift
        endcase
    end

endmodule : dcache_read_merge

// File: src/dcache_ctrl.sv
module dcache_ctrl
#(
    parameter   addr_w = 6,                             // line index width
                tag_w  = 6                              // tag field width
)(
    input   logic                       clk,            // clock
    input   logic                       rst_n_i,        // async reset, active low
    // cpu side, wishbone slave
    input   logic                       cpu_cyc_i,      // bus cycle
    input   logic                       cpu_stb_i,      // strobe
    input   logic                       cpu_we_i,       // store when high
    input   dcache_pkg::word_t          cpu_adr_i,      // byte address
    input   dcache_pkg::size_t          cpu_size_i,     // access size
    input   dcache_pkg::word_t          cpu_dat_i,      // store data, right aligned
    output  logic                       cpu_ack_o,      // request done
    // lookup results
    input   logic                       load_hit_i,     // hit from read merge
    input   dcache_pkg::byte_en_t       lane_vld_i,     // current lane valids
    input   logic                       tag_match_i,    // stored tag equals address tag
    // cache write side
    output  logic   [addr_w-1 : 0]      line_o,         // line index
    output  logic   [tag_w-1  : 0]      wtag_o,         // tag to write and to look up
    output  logic                       tag_we_o,       // tag write enable
    output  dcache_pkg::byte_en_t       lane_we_o,      // per lane write enable
    output  dcache_pkg::byte_en_t       lane_vld_o,     // per lane new valid
    output  dcache_pkg::word_t          lane_wd_o,      // per lane write bytes
    output  dcache_pkg::byte_en_t       rd_en_o,        // lanes a load needs
    // memory side, wishbone master
    output  logic                       mem_cyc_o,      // bus cycle
    output  logic                       mem_stb_o,      // strobe
    output  logic                       mem_we_o,       // write cycle
    output  dcache_pkg::word_t          mem_adr_o,      // word aligned address
    output  dcache_pkg::byte_en_t       mem_sel_o,      // byte selects
    output  dcache_pkg::word_t          mem_dat_o,      // write data
    input   logic                       mem_ack_i,      // memory ack
    input   dcache_pkg::word_t          mem_dat_i       // read data from memory
);

    import dcache_pkg::*;

    typedef enum logic [2 : 0] {
        idle,                                           // wait for a request
        hit_ack,                                        // ack to cpu
        mem_read,                                       // word fetch on miss
        mem_write,                                      // write-through store
        done                                            // fill the line
    } state_t;

    state_t     state_q;                                // current state
    state_t     state_d;                                // next state
    byte_en_t   be;                                     // lanes touched by the access
    byte_en_t   vld_st;                                 // valids after a store
    byte_t      st_b;                                   // low store byte
    word_t      st_dat;                                 // store data on its lanes
    word_t      fill_q;                                 // fetched word

    // byte enables from size and low address bits
    always_comb begin
        case (cpu_size_i)
            SIZE_BYTE   : be = byte_en_t'(4'b0001 << cpu_adr_i[1 : 0]);
            SIZE_HALF   : be = cpu_adr_i[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD   : be = 4'b1111;
            default     : be = 4'b0000;                 // unused encoding
        endcase
    end

    // replicate store data onto every lane it may land on
    assign st_b = cpu_dat_i[7 : 0];

    always_comb begin
        case (cpu_size_i)
            SIZE_BYTE   : st_dat = {4{st_b}};
            SIZE_HALF   : st_dat = {2{cpu_dat_i[15 : 0]}};
            default     : st_dat = cpu_dat_i;
        endcase
    end

    // keep old valids only when the line already holds this tag
    assign vld_st = tag_match_i ? (lane_vld_i | be) : be;

    assign line_o   = cpu_adr_i[addr_w+1 : 2];                  // index field
    assign wtag_o   = cpu_adr_i[tag_w+addr_w+1 : addr_w+2];     // tag field
    assign rd_en_o  = be;                                       // same table for loads

    assign tag_we_o   = (state_q == done) || (state_q == mem_write);
    assign lane_wd_o  = (state_q == done) ? fill_q : st_dat;    // fill or store bytes
    assign lane_vld_o = (state_q == done) ? 4'b1111 : vld_st;

    // lanes losing their valid are written too, which clears them on a retag
    always_comb begin
        case (state_q)
            done        : lane_we_o = 4'b1111;
            mem_write   : lane_we_o = be | ~vld_st;
            default     : lane_we_o = 4'b0000;
        endcase
    end

    assign cpu_ack_o = (state_q == hit_ack);                    // single cycle pulse

    assign mem_cyc_o = (state_q == mem_read) || (state_q == mem_write);
    assign mem_stb_o = mem_cyc_o;                               // rise and fall together
    assign mem_we_o  = (state_q == mem_write);
    assign mem_adr_o = {cpu_adr_i[31 : 2], 2'b00};
    assign mem_sel_o = (state_q == mem_write) ? be : 4'b1111;   // fetch whole word
    assign mem_dat_o = st_dat;

    // capture the fetched word
    always_ff @(posedge clk) begin
        if ((state_q == mem_read) && mem_ack_i) begin
            fill_q <= mem_dat_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle        : begin
                if (cpu_cyc_i && cpu_stb_i) begin
                    if (cpu_we_i) begin
                        state_d = mem_write;            // always write through
                    end else if (load_hit_i) begin
                        state_d = hit_ack;
                    end else begin
                        state_d = mem_read;
                    end
                end
            end
            mem_read    : begin
                if (mem_ack_i) begin
                    state_d = done;
                end
            end
            mem_write   : begin
                if (mem_ack_i) begin
                    state_d = hit_ack;
                end
            end
            done        : state_d = hit_ack;            // lookup hits after the fill
            hit_ack     : state_d = idle;
            default     : state_d = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : dcache_ctrl

// File: src/dcache_top.sv
module dcache_top
#(
    parameter   addr_w = 6,                         // line index width
                tag_w  = 6                          // tag field width
)(
    input   logic                   clk,            // clock
    input   logic                   rst_n_i,        // async reset, active low
    // cpu side, wishbone slave
    input   logic                   cpu_cyc_i,      // bus cycle
    input   logic                   cpu_stb_i,      // strobe
    input   logic                   cpu_we_i,       // store when high
    input   dcache_pkg::word_t      cpu_adr_i,      // byte address
    input   dcache_pkg::size_t      cpu_size_i,     // access size
    input   dcache_pkg::word_t      cpu_dat_i,      // store data
    output  logic                   cpu_ack_o,      // request done
    output  dcache_pkg::word_t      cpu_dat_o,      // load data
    // memory side, wishbone master
    output  logic                   mem_cyc_o,      // bus cycle
    output  logic                   mem_stb_o,      // strobe
    output  logic                   mem_we_o,       // write cycle
    output  dcache_pkg::word_t      mem_adr_o,      // word address
    output  dcache_pkg::byte_en_t   mem_sel_o,      // byte selects
    output  dcache_pkg::word_t      mem_dat_o,      // write data
    input   logic                   mem_ack_i,      // memory ack
    input   dcache_pkg::word_t      mem_dat_i       // read data
);

    import dcache_pkg::*;

    logic   [addr_w-1 : 0]  line;                   // line index
    logic   [tag_w-1  : 0]  wtag;                   // address tag
    logic                   tag_we;                 // tag write
    logic                   tag_match;              // tag compare result
    logic                   load_hit;               // merge hit
    byte_en_t               lane_we;                // bank write enables
    byte_en_t               lane_vld_w;             // valids to banks
    byte_en_t               lane_vld_r;             // valids from banks
    byte_en_t               rd_en;                  // load lanes
    word_t                  lane_wd;                // bytes to banks
    word_t                  lane_rd;                // bytes from banks

    dcache_ctrl #(
        .addr_w         ( addr_w        ),
        .tag_w          ( tag_w         )
    ) u_ctrl (
        .clk            ( clk           ),
        .rst_n_i        ( rst_n_i       ),
        .cpu_cyc_i      ( cpu_cyc_i     ),
        .cpu_stb_i      ( cpu_stb_i     ),
        .cpu_we_i       ( cpu_we_i      ),
        .cpu_adr_i      ( cpu_adr_i     ),
        .cpu_size_i     ( cpu_size_i    ),
        .cpu_dat_i      ( cpu_dat_i     ),
        .cpu_ack_o      ( cpu_ack_o     ),
        .load_hit_i     ( load_hit      ),
        .lane_vld_i     ( lane_vld_r    ),
        .tag_match_i    ( tag_match     ),
        .line_o         ( line          ),
        .wtag_o         ( wtag          ),
        .tag_we_o       ( tag_we        ),
        .lane_we_o      ( lane_we       ),
        .lane_vld_o     ( lane_vld_w    ),
        .lane_wd_o      ( lane_wd       ),
        .rd_en_o        ( rd_en         ),
        .mem_cyc_o      ( mem_cyc_o     ),
        .mem_stb_o      ( mem_stb_o     ),
        .mem_we_o       ( mem_we_o      ),
        .mem_adr_o      ( mem_adr_o     ),
        .mem_sel_o      ( mem_sel_o     ),
        .mem_dat_o      ( mem_dat_o     ),
        .mem_ack_i      ( mem_ack_i     ),
        .mem_dat_i      ( mem_dat_i     )
    );

    // lookup tag and write tag both come from the cpu address
    dcache_tag_store #(
        .addr_w         ( addr_w        ),
        .tag_w          ( tag_w         )
    ) u_tag_store (
        .clk            ( clk           ),
        .line_i         ( line          ),
        .we_i           ( tag_we        ),
        .wtag_i         ( wtag          ),
        .ltag_i         ( wtag          ),
        .tag_match_o    ( tag_match     )
    );

    // one bank per byte lane
    for (genvar i = 0; i < 4; i++) begin : g_bank
        dcache_bank #(
            .addr_w     ( addr_w                )
        ) u_bank (
            .clk        ( clk                   ),
            .rst_n_i    ( rst_n_i               ),
            .line_i     ( line                  ),
            .we_i       ( lane_we[i]            ),
            .vld_i      ( lane_vld_w[i]         ),
            .wd_i       ( lane_wd[i*8 +: 8]     ),
            .vld_o      ( lane_vld_r[i]         ),
            .rd_o       ( lane_rd[i*8 +: 8]     )
        );
    end

    dcache_read_merge u_read_merge (
        .lane_vld_i     ( lane_vld_r        ),
        .tag_match_i    ( tag_match         ),
        .rd_en_i        ( rd_en             ),
        .lane_rd_i      ( lane_rd           ),
        .addr_lo_i      ( cpu_adr_i[1 : 0]  ),
        .size_i         ( cpu_size_i        ),
        .load_hit_o     ( load_hit          ),
        .load_dat_o     ( cpu_dat_o         )
    );

endmodule : dcache_top

// File: dv/dcache_checker.sv
module dcache_checker (
    input   logic                   clk,            // clock
    input   logic                   cpu_stb_i,      // cpu strobe
    input   logic                   cpu_we_i,       // cpu store
    input   logic                   cpu_ack_i,      // cpu ack from dut
    input   dcache_pkg::word_t      load_dat_i,     // load data from dut
    input   logic                   mem_cyc_i,      // memory bus cycle
    input   logic                   mem_stb_i,      // memory strobe
    input   logic                   mem_we_i,       // memory write cycle
    input   logic                   mem_ack_i,      // memory ack
    input   dcache_pkg::word_t      mem_adr_i,      // memory word address
    input   dcache_pkg::byte_en_t   mem_sel_i,      // memory byte selects
    input   dcache_pkg::word_t      wr_dat_i        // memory write data
);

    import dcache_pkg::*;

    string      name;                               // current test
    word_t      exp_dat;                            // expected load word
    word_t      exp_adr;                            // expected bus address
    byte_en_t   exp_sel;                            // expected store selects
    word_t      exp_wdat;                           // expected store bus data
    int         exp_reads;                          // expected fetches or -1 to skip
    int         reads;                              // fetches seen this request
    int         writes;                             // writes seen this request
    int         waits;                              // cycles before ack
    int         data_errs = 0;
    int         bus_errs  = 0;
    int         timeouts  = 0;

    task automatic expect_req(input string n, input word_t d, input word_t a,
                              input byte_en_t s, input word_t w, input int r);
        name      = n;
        exp_dat   = d;
        exp_adr   = a;
        exp_sel   = s;
        exp_wdat  = w;
        exp_reads = r;
        reads     = 0;                              // fresh counts per request
        writes    = 0;
        waits     = 0;
    endtask

    task automatic note_timeout(input string n);
        timeouts++;
        $display("%s: no cpu ack within the timeout", n);
    endtask

    function automatic int total_errors();
        return data_errs + bus_errs + timeouts;
    endfunction

    task automatic report();
        $display("data errors %0d, bus count errors %0d, timeouts %0d",
                 data_errs, bus_errs, timeouts);
    endtask

    // sample between edges where everything is settled
    always @(negedge clk) begin
        if (mem_cyc_i !== mem_stb_i) begin
            bus_errs++;
            $display("%s: memory cyc and stb do not move together", name);
        end
        if (mem_cyc_i && mem_stb_i && mem_ack_i) begin
            if (mem_adr_i !== exp_adr) begin
                data_errs++;
                $display("** Error %s adr: expected %h actual %h", name, exp_adr, mem_adr_i);
            end
            if (mem_we_i) begin
                writes++;
                if (mem_sel_i !== exp_sel) begin
                    data_errs++;
                    $display("** Error %s sel: expected %h actual %h", name, exp_sel, mem_sel_i);
                end
                if (wr_dat_i !== exp_wdat) begin
                    data_errs++;
                    $display("** Error %s wdat: expected %h actual %h", name, exp_wdat, wr_dat_i);
                end
            end else begin
                reads++;
                if (mem_sel_i !== 4'b1111) begin         // fetch takes the whole word
                    data_errs++;
                    $display("** Error %s read sel: expected %h actual %h", name, 4'b1111,
                             mem_sel_i);
                end
            end
        end
        if (cpu_stb_i && !cpu_ack_i) begin
            waits++;
        end
        if (cpu_stb_i && cpu_ack_i) begin
            if (cpu_we_i) begin
                if (writes != 1 || reads != 0) begin
                    bus_errs++;
                    $display("%s: store made %0d memory writes and %0d reads instead of one write",
                             name, writes, reads);
                end
            end else begin
                if (load_dat_i !== exp_dat) begin
                    data_errs++;
                    $display("** Error %s: expected %h actual %h", name, exp_dat, load_dat_i);
                end
                if (exp_reads >= 0 && reads != exp_reads) begin
                    bus_errs++;
                    $display("%s: %0d memory reads, %0d expected", name, reads, exp_reads);
                end
                if (exp_reads == 0 && waits != 1) begin
                    bus_errs++;
                    $display("%s: hit acked after %0d cycles instead of one", name, waits);
                end
            end
        end
    end

endmodule : dcache_checker

// File: dv/dcache_tb.sv
module dcache_tb;

    import dcache_pkg::*;

    localparam  addr_w   = 6;
    localparam  tag_w    = 6;
    localparam  max_wait = 50;                      // cycles before a request times out

    logic       clk;
    logic       rst_n;
    logic       cpu_cyc;
    logic       cpu_stb;
    logic       cpu_we;
    logic       cpu_ack;
    word_t      cpu_adr;
    word_t      cpu_wdat;
    word_t      cpu_rdat;
    size_t      cpu_size;
    logic       mem_cyc;
    logic       mem_stb;
    logic       mem_we;
    logic       mem_ack;
    word_t      mem_adr;
    word_t      mem_wdat;
    word_t      mem_rdat;
    byte_en_t   mem_sel;
    word_t      mem_arr [4096];                     // memory model contents
    word_t      shadow  [4096];                     // expected memory contents
    integer     seed = 44945;
    int         wait_left;                          // wait states still to insert
    bit         busy;                               // memory cycle in progress

    dcache_top #(
        .addr_w     ( addr_w    ),
        .tag_w      ( tag_w     )
    ) UUT (
        .clk        ( clk       ),
        .rst_n_i    ( rst_n     ),
        .cpu_cyc_i  ( cpu_cyc   ),
        .cpu_stb_i  ( cpu_stb   ),
        .cpu_we_i   ( cpu_we    ),
        .cpu_adr_i  ( cpu_adr   ),
        .cpu_size_i ( cpu_size  ),
        .cpu_dat_i  ( cpu_wdat  ),
        .cpu_ack_o  ( cpu_ack   ),
        .cpu_dat_o  ( cpu_rdat  ),
        .mem_cyc_o  ( mem_cyc   ),
        .mem_stb_o  ( mem_stb   ),
        .mem_we_o   ( mem_we    ),
        .mem_adr_o  ( mem_adr   ),
        .mem_sel_o  ( mem_sel   ),
        .mem_dat_o  ( mem_wdat  ),
        .mem_ack_i  ( mem_ack   ),
        .mem_dat_i  ( mem_rdat  )
    );

    dcache_checker u_chk (
        .clk        ( clk       ),
        .cpu_stb_i  ( cpu_stb   ),
        .cpu_we_i   ( cpu_we    ),
        .cpu_ack_i  ( cpu_ack   ),
        .load_dat_i ( cpu_rdat  ),
        .mem_cyc_i  ( mem_cyc   ),
        .mem_stb_i  ( mem_stb   ),
        .mem_we_i   ( mem_we    ),
        .mem_ack_i  ( mem_ack   ),
        .mem_adr_i  ( mem_adr   ),
        .mem_sel_i  ( mem_sel   ),
        .wr_dat_i   ( mem_wdat  )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic byte_en_t byte_sel(input word_t adr, input size_t size);
        case (size)
            SIZE_BYTE   : return 4'b0001 << adr[1 : 0];
            SIZE_HALF   : return 4'b0011 << {adr[1], 1'b0};
            default     : return 4'b1111;
        endcase
    endfunction

    // bus data carries the store bytes on every lane
    function automatic word_t replicate(input word_t dat, input size_t size);
        case (size)
            SIZE_BYTE   : return {4{dat[7 : 0]}};
            SIZE_HALF   : return {2{dat[15 : 0]}};
            default     : return dat;
        endcase
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input byte_en_t sel);
        word_t  res;
        int     i;
        res = old;
        for (i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = nw[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // expected load from a memory word shifted down and zero extended
    function automatic word_t expected_load(input word_t w, input word_t adr, input size_t size);
        case (size)
            SIZE_BYTE   : return (w >> (8 * int'(adr[1 : 0]))) & 32'h0000_00ff;
            SIZE_HALF   : return (w >> (16 * int'(adr[1]))) & 32'h0000_ffff;
            default     : return w;
        endcase
    endfunction

    // wishbone slave with 0 to 3 random wait states
    always @(posedge clk) begin
        #1;
        if (mem_ack) begin
            mem_ack = 1'b0;                         // one cycle ack
        end else if (mem_cyc && mem_stb) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                busy    = 1'b0;
                mem_ack = 1'b1;
                if (mem_we) begin
                    mem_arr[mem_adr[13 : 2]] = merge_bytes(mem_arr[mem_adr[13 : 2]], mem_wdat,
                                                           mem_sel);
                end else begin
                    mem_rdat = mem_arr[mem_adr[13 : 2]];
                end
            end else begin
                wait_left--;
            end
        end
    end

    // one cpu request held until ack
    // reads of -1 skips the fetch count
    task automatic access(input string name, input bit is_store, input word_t adr,
                          input size_t size, input word_t dat, input int reads);
        int n;
        u_chk.expect_req(name, expected_load(shadow[adr[13 : 2]], adr, size),
                         adr & 32'hffff_fffc,
                         byte_sel(adr, size), replicate(dat, size), reads);
        cpu_cyc  = 1'b1;
        cpu_stb  = 1'b1;
        cpu_we   = is_store;
        cpu_adr  = adr;
        cpu_size = size;
        cpu_wdat = dat;
        n = 0;
        @(negedge clk);
        while (!cpu_ack && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ack) begin
            u_chk.note_timeout(name);
        end
        if (is_store) begin
            shadow[adr[13 : 2]] = merge_bytes(shadow[adr[13 : 2]], replicate(dat, size),
                                              byte_sel(adr, size));
        end
        @(posedge clk);
        #1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    initial begin
        int     i;
        int     k;
        word_t  adr;
        size_t  sz;
        bit     st;
        cpu_cyc  = 1'b0;
        cpu_stb  = 1'b0;
        cpu_we   = 1'b0;
        cpu_adr  = '0;
        cpu_size = SIZE_WORD;
        cpu_wdat = '0;
        mem_ack  = 1'b0;
        mem_rdat = '0;
        busy     = 1'b0;
        wait_left = 0;
        for (i = 0; i < 4096; i++) begin
            mem_arr[i] = (word_t'(i) * 32'h9e37_79b1) + 32'h1357_9bdf;
            shadow[i]  = mem_arr[i];
        end
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        access("miss_byte", 0, 32'h011, SIZE_BYTE, 0, 1);   // cold misses of each size
        access("miss_half", 0, 32'h022, SIZE_HALF, 0, 1);
        access("miss_word", 0, 32'h030, SIZE_WORD, 0, 1);
        access("hit_byte", 0, 32'h012, SIZE_BYTE, 0, 0);
        access("hit_half", 0, 32'h020, SIZE_HALF, 0, 0);
        access("hit_word", 0, 32'h010, SIZE_WORD, 0, 0);
        access("store_byte", 1, 32'h031, SIZE_BYTE, 32'h0000_00a5, 0);
        access("store_half", 1, 32'h032, SIZE_HALF, 32'h0000_beef, 0);
        access("merged_load", 0, 32'h030, SIZE_WORD, 0, 0);
        access("store_word", 1, 32'h040, SIZE_WORD, 32'hcafe_f00d, 0);
        access("load_stored", 0, 32'h040, SIZE_WORD, 0, 0);
        access("store_cold", 1, 32'h052, SIZE_HALF, 32'h0000_1234, 0);
        access("partial_hit", 0, 32'h052, SIZE_HALF, 0, 0);
        access("partial_byte", 0, 32'h053, SIZE_BYTE, 0, 0);
        access("partial_miss", 0, 32'h050, SIZE_WORD, 0, 1);
        access("evict", 0, 32'h110, SIZE_WORD, 0, 1);       // same line with another tag
        access("evict_back", 0, 32'h010, SIZE_WORD, 0, 1);
        for (k = 0; k < 200; k++) begin
            sz  = size_t'($unsigned($random(seed)) % 3);
            adr = (($unsigned($random(seed)) % 4) << 8) | (($unsigned($random(seed)) % 4) << 2);
            if (sz == SIZE_BYTE) begin
                adr[1 : 0] = 2'($unsigned($random(seed)) % 4);
            end else if (sz == SIZE_HALF) begin
                adr[1] = 1'($random(seed) & 1);
            end
            st = 1'($random(seed) & 1);
            access("random", st, adr, sz, $random(seed), -1);
        end
        u_chk.report();
        if (u_chk.total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : dcache_tb

// File: dcache.f
src/dcache_pkg.sv
src/dcache_bank.sv
src/dcache_tag_store.sv
src/dcache_read_merge.sv
src/dcache_ctrl.sv
src/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_tb -f dcache.f -o sim_dcache
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
